// File: project.f
imuldiv_pkg.sv
int_div_dpath.sv
int_div_ctrl.sv
int_div_iterative.sv
int_mul_iterative.sv
imuldiv_unit.sv
imuldiv_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = imuldiv_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Verification passed
FAIL_MSG  = Verification failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: imuldiv_tb.sv
// ----------------------------------------
// imuldiv testbench with directed and random mul/div
// traffic against a reference model and handshake checks
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module imuldiv_tb import imuldiv_pkg::*; ();

  localparam int clk_period = 20;
  localparam int max_stall  = 6;
  // operation counts per group
  localparam int n_directed = 26;
  localparam int n_divu_rnd = 50;
  localparam int n_div_rnd  = 30;
  localparam int n_mul_rnd  = 40;
  localparam int n_mix      = 24;
  localparam int num_ops    = n_directed + n_divu_rnd + n_div_rnd + n_mul_rnd + n_mix;
  localparam int watchdog_ns = num_ops * (32 + max_stall + 10) * clk_period;

  logic        clk;
  logic        reset;
  muldiv_req_t req;
  logic        req_val;
  logic        req_rdy;
  result_t     resp;
  logic        resp_val;
  logic        resp_rdy;

  int    seed = 32'h3359_9fd3;
  int    cycle = 0;
  int    pass_count = 0;
  int    fail_count = 0;
  int    test_fails;
  int    test_checks;
  string cur_test;

  imuldiv_unit u_dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // count of rising edges that the falling edge side reads
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ----------------------------------------
  // handshake rules
  // ----------------------------------------

  // no new request while a response is pending
  assert property (@(posedge clk) disable iff (reset) resp_val |-> !req_rdy)
    else begin
      $display("handshake error: req_rdy high while a response is pending");
      fail_count++;
    end

  // accepted request makes the unit busy
  assert property (@(posedge clk) disable iff (reset) (req_val && req_rdy) |=> !req_rdy)
    else begin
      $display("handshake error: req_rdy stayed high after a request was accepted");
      fail_count++;
    end

  // back-pressure holds the response steady
  assert property (@(posedge clk) disable iff (reset)
                   (resp_val && !resp_rdy) |=> (resp_val && $stable(resp)))
    else begin
      $display("handshake error: response changed or dropped while stalled");
      fail_count++;
    end

  // transfer frees the unit for the next cycle
  assert property (@(posedge clk) disable iff (reset)
                   (resp_val && resp_rdy) |=> (req_rdy && !resp_val))
    else begin
      $display("handshake error: unit not idle in the cycle after a transfer");
      fail_count++;
    end

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  function automatic result_t expected_result(input muldiv_fn_t f, input operand_t a,
                                              input operand_t b);
    logic signed [63:0] pa;
    logic signed [63:0] pb;
    logic               sa;
    logic               sb;
    operand_t           am;
    operand_t           bm;
    operand_t           qm;
    operand_t           rm;
    operand_t           q;
    operand_t           r;
    if (f == fn_mul) begin
      pa = {{32{a[31]}}, a};
      pb = {{32{b[31]}}, b};
      return pa * pb;
    end
    // only the signed divide sees sign bits
    sa = (f == fn_div) & a[31];
    sb = (f == fn_div) & b[31];
    am = sa ? (32'd0 - a) : a;
    bm = sb ? (32'd0 - b) : b;
    // zero divisor gives an all ones quotient and the dividend as remainder
    qm = (bm == 32'd0) ? 32'hffff_ffff : am / bm;
    rm = (bm == 32'd0) ? am : am % bm;
    q  = (sa ^ sb) ? (32'd0 - qm) : qm;
    r  = sa ? (32'd0 - rm) : rm;
    return {r, q};
  endfunction

  // ----------------------------------------
  // checks and bookkeeping
  // ----------------------------------------

  task automatic check_value(input string what, input result_t expected, input result_t actual);
    assert (actual === expected) begin
      pass_count++;
    end else begin
      $display("Fail %s: expected %h, actual %h", what, expected, actual);
      fail_count++;
    end
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    assert (actual == expected) begin
      pass_count++;
    end else begin
      $display("Fail %s: expected %0d, actual %0d", what, expected, actual);
      fail_count++;
    end
  endtask

  task automatic flag_error(input string msg);
    $display("%s", msg);
    fail_count++;
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_fails  = fail_count;
    test_checks = pass_count + fail_count;
  endtask

  task automatic end_test();
    $display("test %s: %0d checks, %0d errors", cur_test,
             pass_count + fail_count - test_checks, fail_count - test_fails);
  endtask

  // wide spread of magnitudes including small values
  function automatic operand_t random_operand();
    operand_t raw;
    int       sh;
    raw = $random(seed);
    sh  = ($random(seed) & 32'h7fff_ffff) % 32;
    return operand_t'($signed(raw) >>> sh);
  endfunction

  // ----------------------------------------
  // request and response tasks
  // ----------------------------------------

  // entered on a falling edge and left on the falling edge after acceptance
  task automatic send_request(input muldiv_fn_t f, input operand_t a, input operand_t b,
                              output int accept_cycle);
    req.fn  = f;
    req.a   = a;
    req.b   = b;
    req_val = 1'b1;
    while (!req_rdy) begin
      @(negedge clk);
    end
    // request transfers on this edge
    @(posedge clk);
    @(negedge clk);
    accept_cycle = cycle;
    req_val      = 1'b0;
  endtask

  // waits for resp_val and holds resp_rdy low for a random stall before the transfer
  task automatic take_response(input string name, input int accept_cycle, input int stall_max,
                               output result_t got);
    int stall;
    while (!resp_val) begin
      assert (!req_rdy)
        else flag_error($sformatf("%s: req_rdy high during the calculation", name));
      @(negedge clk);
    end
    check_count({name, " latency"}, 32, cycle - accept_cycle);
    stall = (stall_max > 0) ? ($random(seed) & 32'h7fff_ffff) % (stall_max + 1) : 0;
    repeat (stall) begin
      @(negedge clk);
      assert (resp_val)
        else flag_error($sformatf("%s: resp_val dropped while stalled", name));
    end
    got      = resp;
    resp_rdy = 1'b1;
    @(posedge clk);
    @(negedge clk);
    resp_rdy = 1'b0;
    assert (req_rdy && !resp_val)
      else flag_error($sformatf("%s: unit did not return to idle after the transfer", name));
  endtask

  task automatic run_op(input string name, input muldiv_fn_t f, input operand_t a,
                        input operand_t b, input int stall_max);
    result_t exp;
    result_t got;
    int      accept_cycle;
    exp = expected_result(f, a, b);
    send_request(f, a, b, accept_cycle);
    take_response(name, accept_cycle, stall_max, got);
    check_value(name, exp, got);
  endtask

  // ----------------------------------------
  // watchdog
  // ----------------------------------------

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before all operations completed");
    $display("Verification failed");
    $finish;
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial begin
    muldiv_fn_t f;
    int         pick;
    reset    = 1'b1;
    req      = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    begin_test("reset");
    check_count("reset req_rdy", 1, int'(req_rdy));
    check_count("reset resp_val", 0, int'(resp_val));
    end_test();

    begin_test("divu");
    run_op("divu 100/7", fn_divu, 32'd100, 32'd7, 0);
    run_op("divu x/1", fn_divu, 32'hffff_ffff, 32'd1, 0);
    run_op("divu x/x", fn_divu, 32'd12345, 32'd12345, 0);
    run_op("divu max/max", fn_divu, 32'hffff_ffff, 32'hffff_ffff, 0);
    run_op("divu 7/100", fn_divu, 32'd7, 32'd100, 0);
    run_op("divu top/3", fn_divu, 32'h8000_0000, 32'd3, 0);
    for (int i = 0; i < n_divu_rnd; i++) begin
      run_op($sformatf("divu rand %0d", i), fn_divu, $random(seed), random_operand(), 0);
    end
    end_test();

    begin_test("div");
    run_op("div +/+", fn_div, 32'd100, 32'd7, 0);
    run_op("div -/+", fn_div, -32'sd100, 32'd7, 0);
    run_op("div +/-", fn_div, 32'd100, -32'sd7, 0);
    run_op("div -/-", fn_div, -32'sd100, -32'sd7, 0);
    run_op("div min/-1", fn_div, 32'h8000_0000, 32'hffff_ffff, 0);
    run_op("div min/1", fn_div, 32'h8000_0000, 32'd1, 0);
    run_op("div -1/min", fn_div, 32'hffff_ffff, 32'h8000_0000, 0);
    for (int i = 0; i < n_div_rnd; i++) begin
      run_op($sformatf("div rand %0d", i), fn_div, $random(seed), random_operand(), 0);
    end
    end_test();

    begin_test("div0");
    run_op("divu 1234/0", fn_divu, 32'd1234, 32'd0, 0);
    run_op("divu 0/0", fn_divu, 32'd0, 32'd0, 0);
    run_op("div -7/0", fn_div, -32'sd7, 32'd0, 0);
    run_op("div 7/0", fn_div, 32'd7, 32'd0, 0);
    run_op("div min/0", fn_div, 32'h8000_0000, 32'd0, 0);
    end_test();

    begin_test("mul");
    run_op("mul x*1", fn_mul, 32'h1234_5678, 32'd1, 0);
    run_op("mul x*-1", fn_mul, 32'h1234_5678, 32'hffff_ffff, 0);
    run_op("mul 0*x", fn_mul, 32'd0, 32'hdead_beef, 0);
    run_op("mul min*min", fn_mul, 32'h8000_0000, 32'h8000_0000, 0);
    run_op("mul min*-1", fn_mul, 32'h8000_0000, 32'hffff_ffff, 0);
    run_op("mul -1*-1", fn_mul, 32'hffff_ffff, 32'hffff_ffff, 0);
    run_op("mul max*max", fn_mul, 32'h7fff_ffff, 32'h7fff_ffff, 0);
    run_op("mul min*1", fn_mul, 32'h8000_0000, 32'd1, 0);
    for (int i = 0; i < n_mul_rnd; i++) begin
      run_op($sformatf("mul rand %0d", i), fn_mul, $random(seed), random_operand(), 0);
    end
    end_test();

    // back to back mixed traffic with random back-pressure
    begin_test("stall mix");
    for (int i = 0; i < n_mix; i++) begin
      pick = ($random(seed) & 32'h7fff_ffff) % 3;
      case (pick)
        0: f = fn_mul;
        1: f = fn_div;
        default: f = fn_divu;
      endcase
      run_op($sformatf("mix %0d", i), f, $random(seed), random_operand(), max_stall);
    end
    end_test();

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: imuldiv_unit.sv
// ----------------------------------------
// multiply/divide unit: steers requests by function
// code, one operation in flight, merges responses
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module imuldiv_unit import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  muldiv_req_t req,
  input  logic        req_val,
  output logic        req_rdy,
  output result_t     resp,
  output logic        resp_val,
  input  logic        resp_rdy
);

  // per engine handshake
  logic    mul_req_val;
  logic    mul_req_rdy;
  result_t mul_resp;
  logic    mul_resp_val;

  logic    div_req_val;
  logic    div_req_rdy;
  result_t div_resp;
  logic    div_resp_val;

  logic is_mul;

  assign is_mul = (req.fn == fn_mul);

  // both idle before anything is taken
  assign req_rdy = mul_req_rdy & div_req_rdy;

  // gate with req_rdy so an idle engine never starts beside a busy one
  assign mul_req_val = req_val & req_rdy & is_mul;
  assign div_req_val = req_val & req_rdy & ~is_mul;

  // ----------------------------------------
  // engines
  // ----------------------------------------

  int_mul_iterative u_mul (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp     (mul_resp),
    .resp_val (mul_resp_val),
    .resp_rdy (resp_rdy)
  );

  int_div_iterative u_div (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp     (div_resp),
    .resp_val (div_resp_val),
    .resp_rdy (resp_rdy)
  );

  // at most one engine is ever valid
  assign resp_val = mul_resp_val | div_resp_val;
  assign resp     = mul_resp_val ? mul_resp : div_resp;

endmodule

`default_nettype wire

// File: int_mul_iterative.sv
// ----------------------------------------
// iterative signed multiplier: shift and add over
// magnitudes, 32 steps, product negated on sign mismatch
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module int_mul_iterative import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  muldiv_req_t req,
  input  logic        req_val,
  output logic        req_rdy,
  output result_t     resp,
  output logic        resp_val,
  input  logic        resp_rdy
);

  mul_state_t state;
  iter_t      count;
  logic       neg;

  logic req_go;
  logic resp_go;

  assign req_rdy  = (state == st_mul_idle);
  assign resp_val = (state == st_mul_done);
  assign req_go   = req_val & req_rdy;
  assign resp_go  = resp_val & resp_rdy;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------

  operand_t a_mag;
  operand_t b_mag;

  assign a_mag = req.a[31] ? (~req.a + 32'd1) : req.a;
  assign b_mag = req.b[31] ? (~req.b + 32'd1) : req.b;

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  // multiplicand moves left, multiplier moves right
  result_t  mcand;
  operand_t mplier;
  result_t  acc;

  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand  <= {32'b0, a_mag};
      mplier <= b_mag;
      acc    <= '0;
    end else if (state == st_mul_calc) begin
      // add only when the low multiplier bit is set
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // ----------------------------------------
  // FSM
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_mul_idle;
      count <= '0;
      neg   <= 1'b0;
    end else begin
      case (state)
        st_mul_idle: begin
          if (req_go) begin
            state <= st_mul_calc;
            count <= '0;
            neg   <= req.a[31] ^ req.b[31];
          end
        end
        st_mul_calc: begin
          if (count == last_iter) begin
            state <= st_mul_done;
          end else begin
            count <= count + 5'd1;
          end
        end
        st_mul_done: begin
          if (resp_go) begin
            state <= st_mul_idle;
          end
        end
        default: begin
          state <= st_mul_idle;
        end
      endcase
    end
  end

  // magnitude product fits in 63 bits, so negation is exact
  assign resp = neg ? (~acc + 64'd1) : acc;

endmodule

`default_nettype wire

// File: int_div_iterative.sv
// ----------------------------------------
// iterative divider: control unit plus datapath
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module int_div_iterative import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  muldiv_req_t req,
  input  logic        req_val,
  output logic        req_rdy,
  output result_t     resp,
  output logic        resp_val,
  input  logic        resp_rdy
);

  // commands and mode from control
  div_ctrl_t ctrl;
  logic      is_signed;

  int_div_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .fn        (req.fn),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .ctrl      (ctrl),
    .is_signed (is_signed)
  );

  int_div_dpath u_dpath (
    .clk       (clk),
    .reset     (reset),
    .a         (req.a),
    .b         (req.b),
    .ctrl      (ctrl),
    .is_signed (is_signed),
    .result    (resp)
  );

endmodule

`default_nettype wire

// File: int_div_ctrl.sv
// ----------------------------------------
// divider control: idle/calc/done FSM with a 32 step
// counter, datapath commands and val/rdy
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module int_div_ctrl import imuldiv_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  muldiv_fn_t fn,
  input  logic       req_val,
  output logic       req_rdy,
  output logic       resp_val,
  input  logic       resp_rdy,
  output div_ctrl_t  ctrl,
  output logic       is_signed
);

  div_state_t state;
  iter_t      count;
  logic       is_signed_q;

  // handshake events
  logic req_go;
  logic resp_go;

  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  // ----------------------------------------
  // state, counter and mode register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_idle;
      count       <= '0;
      is_signed_q <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state       <= st_calc;
            count       <= '0;
            is_signed_q <= (fn == fn_div);
          end
        end
        st_calc: begin
          // step 32 lands in done
          if (count == last_iter) begin
            state <= st_done;
          end else begin
            count <= count + 5'd1;
          end
        end
        st_done: begin
          // hold until the response is taken
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ----------------------------------------
  // outputs per state
  // ----------------------------------------

  always_comb begin
    ctrl     = '0;
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    case (state)
      st_idle: begin
        req_rdy      = 1'b1;
        // load operands and signs on acceptance
        ctrl.a_en    = req_go;
        ctrl.b_en    = req_go;
        ctrl.sign_en = req_go;
      end
      st_calc: begin
        ctrl.a_en      = 1'b1;
        ctrl.a_mux_sel = 1'b1;
      end
      st_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  // live decode while idle so the accepting edge loads magnitudes,
  // held copy afterwards
  assign is_signed = (state == st_idle) ? (fn == fn_div) : is_signed_q;

endmodule

`default_nettype wire

// File: int_div_dpath.sv
// ----------------------------------------
// divider datapath: restoring shift and subtract over
// operand magnitudes, sign fix on the way out
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module int_div_dpath import imuldiv_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  operand_t  a,
  input  operand_t  b,
  input  div_ctrl_t ctrl,
  input  logic      is_signed,
  output result_t   result
);

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------

  // only signed divide treats the top bit as a sign
  logic     a_neg_in;
  logic     b_neg_in;
  operand_t a_mag;
  operand_t b_mag;

  assign a_neg_in = is_signed & a[31];
  assign b_neg_in = is_signed & b[31];
  // most negative value maps to 2^31, still fits unsigned
  assign a_mag = a_neg_in ? (~a + 32'd1) : a;
  assign b_mag = b_neg_in ? (~b + 32'd1) : b;

  // ----------------------------------------
  // iteration step
  // ----------------------------------------

  // remainder in [63:32], quotient grows in [31:0]
  div_wide_t rq_reg;
  // divisor sits above the quotient field
  div_wide_t dvs_reg;

  div_wide_t rq_shift;
  div_wide_t diff;
  div_wide_t rq_step;
  logic      sub_neg;

  assign rq_shift = rq_reg << 1;
  assign diff     = rq_shift - dvs_reg;
  // bit 64 set means the divisor did not fit
  assign sub_neg  = diff[64];

  always_comb begin
    if (sub_neg) begin
      // restore, quotient bit 0
      rq_step = {rq_shift[64:1], 1'b0};
    end else begin
      // keep the difference, quotient bit 1
      rq_step = {diff[64:1], 1'b1};
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.a_en) begin
      rq_reg <= ctrl.a_mux_sel ? rq_step : {33'b0, a_mag};
    end
    if (ctrl.b_en) begin
      dvs_reg <= {1'b0, b_mag, 32'b0};
    end
  end

  // operand signs, captured with the operands
  logic a_neg;
  logic b_neg;

  always_ff @(posedge clk) begin
    if (reset) begin
      a_neg <= 1'b0;
      b_neg <= 1'b0;
    end else if (ctrl.sign_en) begin
      a_neg <= a_neg_in;
      b_neg <= b_neg_in;
    end
  end

  // ----------------------------------------
  // sign correction
  // ----------------------------------------

  operand_t quot_mag;
  operand_t rem_mag;
  operand_t quot;
  operand_t rem;

  assign quot_mag = rq_reg[31:0];
  assign rem_mag  = rq_reg[63:32];

  // quotient negative when the signs differ
  assign quot = (a_neg ^ b_neg) ? (~quot_mag + 32'd1) : quot_mag;
  // remainder follows the dividend
  assign rem  = a_neg ? (~rem_mag + 32'd1) : rem_mag;

  assign result = {rem, quot};

endmodule

`default_nettype wire

// File: imuldiv_pkg.sv
// ----------------------------------------
// imuldiv shared types: function codes, operand and
// result vectors, request message, divider commands
// ----------------------------------------
`default_nettype none

package imuldiv_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  // one source operand
  typedef logic [31:0] operand_t;
  // response payload, high half remainder or product top
  typedef logic [63:0] result_t;
  // divider remainder/quotient and divisor registers
  typedef logic [64:0] div_wide_t;
  // iteration counter, one step per operand bit
  typedef logic [4:0] iter_t;

  // last step index, 32 steps in total
  localparam iter_t last_iter = 5'd31;

  // request function
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } muldiv_fn_t;

  // request message, 66 bits
  typedef struct packed {
    muldiv_fn_t fn;
    operand_t   a;
    operand_t   b;
  } muldiv_req_t;

  // divider control to datapath
  typedef struct packed {
    logic a_en;
    // 0 loads the dividend, 1 iterates
    logic a_mux_sel;
    logic b_en;
    logic sign_en;
  } div_ctrl_t;

  // divider FSM
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } div_state_t;

  // multiplier FSM
  typedef enum logic [1:0] {
    st_mul_idle = 2'd0,
    st_mul_calc = 2'd1,
    st_mul_done = 2'd2
  } mul_state_t;

endpackage

`default_nettype wire
